// ==== source/b2s_params.svh ====
`ifndef B2S_PARAMS_SVH
`define B2S_PARAMS_SVH

// Bus widths
`define B2S_ADDR_WIDTH 32
`define B2S_DATA_WIDTH 32
`define B2S_ID_WIDTH   4

// AXI burst length field
`define B2S_LEN_WIDTH  8

// Full-width beats only
`define B2S_BEAT_BYTES 4

// Entries per R buffer, power of two
`define B2S_R_DEPTH    8

`endif

// ==== source/b2s_pkg.sv ====
`include "b2s_params.svh"

package b2s_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI burst encoding, FIXED not supported
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    BURST_INCR = 2'b01,
    BURST_WRAP = 2'b10
  } burst_t;

  // One tag per issued beat
  typedef struct packed {
    logic [`B2S_ID_WIDTH-1:0] id;
    logic                     last;  // Final beat of the burst
  } r_tag_t;

endpackage

// ==== source/b2s_rd_if.sv ====
`timescale 1ns/1ps

interface b2s_rd_if;
  import b2s_pkg::*;

  logic   next;          // Beat accepted on master bus
  logic   next_pending;  // More beats after this one
  logic   a_push;        // FSM idle, load new command
  logic   r_push;        // Write tag for issued beat
  r_tag_t r_tag;         // Tag of current beat
  logic   data_ready;    // Room for another outstanding beat

  modport fsm_mp (
    output next, a_push, r_push,
    input  next_pending, data_ready
  );

  modport xlat_mp (
    input  next, a_push,
    output next_pending, r_tag
  );

  modport rch_mp (
    input  r_push, r_tag,
    output data_ready
  );

endinterface

// ==== source/b2s_rd_cmd_fsm.sv ====
`timescale 1ns/1ps

module b2s_rd_cmd_fsm (
  input  logic clk,
  input  logic reset,
  input  logic s_arvalid,
  output logic s_arready,
  output logic m_arvalid,
  input  logic m_arready,
  b2s_rd_if.fsm_mp ctl
);

  localparam logic [1:0] IDLE         = 2'b00;
  localparam logic [1:0] CMD_EN       = 2'b01;
  localparam logic [1:0] CMD_ACCEPTED = 2'b10;
  localparam logic [1:0] DONE         = 2'b11;

  logic [1:0] state;
  logic [1:0] next_state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (s_arvalid && ctl.data_ready) begin
          next_state = CMD_EN;
        end
      end
      CMD_EN: begin
        if (m_arready && ctl.next_pending && !ctl.data_ready) begin
          next_state = CMD_ACCEPTED;  // Wait for buffer room
        end else if (m_arready && !ctl.next_pending) begin
          next_state = DONE;
        end else begin
          next_state = CMD_EN;
        end
      end
      CMD_ACCEPTED: begin
        if (ctl.data_ready) begin
          next_state = CMD_EN;
        end
      end
      DONE: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  assign m_arvalid  = (state == CMD_EN);
  assign ctl.next   = m_arready && (state == CMD_EN);
  assign ctl.r_push = ctl.next;
  assign ctl.a_push = (state == IDLE);
  assign s_arready  = (state == DONE);  // One pulse per command

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_arvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    m_arvalid && !m_arready |=> m_arvalid
  );

  // Command ends only right after its last beat
  a_arready_done: assert property (
    @(posedge clk) disable iff (reset)
    s_arready |-> $past(ctl.next && !ctl.next_pending)
  );

endmodule

// ==== source/b2s_cmd_translator.sv ====
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_cmd_translator (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`B2S_ID_WIDTH-1:0]   s_arid,
  input  logic [`B2S_ADDR_WIDTH-1:0] s_araddr,
  input  logic [`B2S_LEN_WIDTH-1:0]  s_arlen,
  input  b2s_pkg::burst_t            s_arburst,
  output logic [`B2S_ADDR_WIDTH-1:0] m_araddr,
  b2s_rd_if.xlat_mp ctl
);
  import b2s_pkg::*;

  localparam int AW = `B2S_ADDR_WIDTH;

  logic [AW-1:0]                addr_r;
  logic [AW-1:0]                wrap_mask_r;
  logic [`B2S_ID_WIDTH-1:0]     id_r;
  logic [`B2S_LEN_WIDTH-1:0]    beats_left;  // Beats after the current one
  burst_t                       burst_r;

  logic [AW-1:0] arlen_ext;
  logic [AW-1:0] wrap_mask;
  logic [AW-1:0] addr_incr;
  logic [AW-1:0] addr_wrap;

  // Boundary is beat size times burst length
  assign arlen_ext = AW'(s_arlen);
  assign wrap_mask = ((arlen_ext + AW'(1)) * AW'(`B2S_BEAT_BYTES)) - AW'(1);

  assign addr_incr = addr_r + AW'(`B2S_BEAT_BYTES);
  assign addr_wrap = (addr_r & ~wrap_mask_r) | (addr_incr & wrap_mask_r);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      beats_left <= '0;
    end else if (ctl.a_push) begin
      beats_left <= s_arlen;
    end else if (ctl.next && beats_left != '0) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  // Address and command fields
  always_ff @(posedge clk) begin
    if (ctl.a_push) begin
      addr_r      <= s_araddr;
      id_r        <= s_arid;
      burst_r     <= s_arburst;
      wrap_mask_r <= wrap_mask;
    end else if (ctl.next) begin
      if (burst_r == BURST_WRAP) begin
        addr_r <= addr_wrap;  // Upper bits kept
      end else begin
        addr_r <= addr_incr;
      end
    end
  end

  assign m_araddr         = addr_r;
  assign ctl.next_pending = (beats_left != '0);
  assign ctl.r_tag.id     = id_r;
  assign ctl.r_tag.last   = (beats_left == '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Captured length checked when the FSM takes the command
  a_wrap_len: assert property (
    @(posedge clk) disable iff (reset)
    $fell(ctl.a_push) && (burst_r == BURST_WRAP)
      |-> beats_left inside {8'd1, 8'd3, 8'd7, 8'd15}
  );

endmodule

// ==== source/b2s_r_channel.sv ====
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_r_channel (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`B2S_DATA_WIDTH-1:0] m_rdata,
  input  logic                       m_rvalid,
  output logic                       m_rready,
  output logic [`B2S_ID_WIDTH-1:0]   s_rid,
  output logic [`B2S_DATA_WIDTH-1:0] s_rdata,
  output logic                       s_rlast,
  output logic                       s_rvalid,
  input  logic                       s_rready,
  b2s_rd_if.rch_mp ctl
);
  import b2s_pkg::*;

  localparam int PTR_W = $clog2(`B2S_R_DEPTH);
  localparam int CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`B2S_R_DEPTH);

  r_tag_t                     tag_mem  [`B2S_R_DEPTH];
  logic [`B2S_DATA_WIDTH-1:0] data_mem [`B2S_R_DEPTH];

  logic [PTR_W-1:0] tag_wr_ptr;
  logic [PTR_W-1:0] data_wr_ptr;
  logic [PTR_W-1:0] rd_ptr;    // Both buffers pop together
  logic [CNT_W-1:0] tag_cnt;   // Outstanding beats
  logic [CNT_W-1:0] data_cnt;

  logic tag_push;
  logic data_push;
  logic pop;

  assign tag_push  = ctl.r_push;
  assign data_push = m_rvalid && m_rready;
  assign pop       = s_rvalid && s_rready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and counts
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_wr_ptr  <= '0;
      data_wr_ptr <= '0;
      rd_ptr      <= '0;
      tag_cnt     <= '0;
      data_cnt    <= '0;
    end else begin
      if (tag_push) begin
        tag_wr_ptr <= tag_wr_ptr + 1'b1;
      end
      if (data_push) begin
        data_wr_ptr <= data_wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      tag_cnt  <= tag_cnt + CNT_W'(tag_push) - CNT_W'(pop);
      data_cnt <= data_cnt + CNT_W'(data_push) - CNT_W'(pop);
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (tag_push) begin
      tag_mem[tag_wr_ptr] <= ctl.r_tag;
    end
    if (data_push) begin
      data_mem[data_wr_ptr] <= m_rdata;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Slave R side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign s_rvalid = (tag_cnt != '0) && (data_cnt != '0);
  assign s_rid    = tag_mem[rd_ptr].id;
  assign s_rlast  = tag_mem[rd_ptr].last;
  assign s_rdata  = data_mem[rd_ptr];

  assign m_rready = (data_cnt != DEPTH);

  // Counts the beat being pushed now, so the FSM stops in time
  assign ctl.data_ready = ((tag_cnt + CNT_W'(tag_push)) < DEPTH);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_tag_overflow: assert property (
    @(posedge clk) disable iff (reset)
    tag_push |-> (tag_cnt != DEPTH)
  );

  // Master returns only what was issued
  a_data_orphan: assert property (
    @(posedge clk) disable iff (reset)
    data_push |-> (data_cnt < tag_cnt)
  );

endmodule

// ==== source/b2s_rd_top.sv ====
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_rd_top (
  input  logic                       clk,
  input  logic                       reset,
  // Slave AR
  input  logic [`B2S_ID_WIDTH-1:0]   s_arid,
  input  logic [`B2S_ADDR_WIDTH-1:0] s_araddr,
  input  logic [`B2S_LEN_WIDTH-1:0]  s_arlen,
  input  logic [1:0]                 s_arburst,
  input  logic                       s_arvalid,
  output logic                       s_arready,
  // Slave R
  output logic [`B2S_ID_WIDTH-1:0]   s_rid,
  output logic [`B2S_DATA_WIDTH-1:0] s_rdata,
  output logic                       s_rlast,
  output logic                       s_rvalid,
  input  logic                       s_rready,
  // Master command
  output logic [`B2S_ADDR_WIDTH-1:0] m_araddr,
  output logic                       m_arvalid,
  input  logic                       m_arready,
  // Master return
  input  logic [`B2S_DATA_WIDTH-1:0] m_rdata,
  input  logic                       m_rvalid,
  output logic                       m_rready
);
  import b2s_pkg::*;

  b2s_rd_if rd_if ();

  b2s_rd_cmd_fsm b2s_rd_cmd_fsm_inst (
    .clk       (clk),
    .reset     (reset),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .ctl       (rd_if.fsm_mp)
  );

  b2s_cmd_translator b2s_cmd_translator_inst (
    .clk       (clk),
    .reset     (reset),
    .s_arid    (s_arid),
    .s_araddr  (s_araddr),
    .s_arlen   (s_arlen),
    .s_arburst (burst_t'(s_arburst)),  // Plain bits at the pins
    .m_araddr  (m_araddr),
    .ctl       (rd_if.xlat_mp)
  );

  b2s_r_channel b2s_r_channel_inst (
    .clk      (clk),
    .reset    (reset),
    .m_rdata  (m_rdata),
    .m_rvalid (m_rvalid),
    .m_rready (m_rready),
    .s_rid    (s_rid),
    .s_rdata  (s_rdata),
    .s_rlast  (s_rlast),
    .s_rvalid (s_rvalid),
    .s_rready (s_rready),
    .ctl      (rd_if.rch_mp)
  );

endmodule

// ==== verification/b2s_rd_tb.sv ====
`timescale 1ns/1ps
`include "b2s_params.svh"

module b2s_rd_tb;
  import b2s_pkg::*;

  localparam int NUM_CMDS = 11;
  localparam int DEPTH    = `B2S_R_DEPTH;

  logic        clk       = 1'b0;
  logic        reset     = 1'b1;
  logic [3:0]  s_arid    = '0;
  logic [31:0] s_araddr  = '0;
  logic [7:0]  s_arlen   = '0;
  logic [1:0]  s_arburst = '0;
  logic        s_arvalid = 1'b0;
  logic        s_arready;
  logic [3:0]  s_rid;
  logic [31:0] s_rdata;
  logic        s_rlast;
  logic        s_rvalid;
  logic        s_rready  = 1'b0;
  logic [31:0] m_araddr;
  logic        m_arvalid;
  logic        m_arready = 1'b0;
  logic [31:0] m_rdata   = '0;
  logic        m_rvalid  = 1'b0;
  logic        m_rready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [3:0]  tbl_id [NUM_CMDS] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7,
                                     4'd8, 4'd9, 4'd10, 4'd11};
  logic [31:0] tbl_addr [NUM_CMDS] = '{32'h1000, 32'h2004, 32'h3010, 32'h4004,
                                       32'h5008, 32'h6014, 32'h7028, 32'h8000,
                                       32'h8104, 32'h8208, 32'h830C};
  int          tbl_len [NUM_CMDS] = '{0, 3, 15, 1, 3, 7, 15, 0, 0, 0, 0};
  burst_t      tbl_burst [NUM_CMDS] = '{BURST_INCR, BURST_INCR, BURST_INCR,
                                        BURST_WRAP, BURST_WRAP, BURST_WRAP,
                                        BURST_WRAP, BURST_INCR, BURST_INCR,
                                        BURST_INCR, BURST_INCR};

  logic [31:0] exp_maddr [$];  // Master bus order
  logic [31:0] exp_raddr [$];
  logic [3:0]  exp_rid [$];
  logic        exp_rlast [$];
  logic [31:0] ret_q [$];      // Accepted but not yet returned
  int          cum_beats [NUM_CMDS];

  int          total_beats = 0;
  int          issued_cnt  = 0;
  int          popped_cnt  = 0;
  int          ar_cnt      = 0;
  int          ret_wait    = 0;
  int          stall_left  = 0;
  logic [31:0] ret_addr;
  logic [31:0] r_addr;
  logic [31:0] lfsr_state  = 32'd72713;

  always #4 clk = ~clk;

  b2s_rd_top b2s_rd_top_inst (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
    return b;
  endfunction

  function automatic logic [3:0] take_bits(input int count);
    logic [3:0] bits;
    bits = '0;
    for (int k = 0; k < count; k++) begin
      bits = {bits[2:0], take_bit()};
    end
    return bits;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, what, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // Beat addresses from the AXI INCR and WRAP rules
  task automatic build_expected();
    logic [31:0] bytes;
    logic [31:0] base;
    logic [31:0] addr;
    for (int c = 0; c < NUM_CMDS; c++) begin
      bytes = 32'(4 * (tbl_len[c] + 1));
      base  = tbl_addr[c] & ~(bytes - 32'd1);
      for (int b = 0; b <= tbl_len[c]; b++) begin
        if (tbl_burst[c] == BURST_WRAP) begin
          addr = base + ((tbl_addr[c] - base + 32'(4 * b)) % bytes);
        end else begin
          addr = tbl_addr[c] + 32'(4 * b);
        end
        exp_maddr.push_back(addr);
        exp_raddr.push_back(addr);
        exp_rid.push_back(tbl_id[c]);
        exp_rlast.push_back(b == tbl_len[c]);
        total_beats++;
      end
      cum_beats[c] = total_beats;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Master bus memory model and R back-pressure
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (!reset) begin
      if (m_arvalid && m_arready) begin
        check_value("Master beat expected", 32'd1, 32'(exp_maddr.size() != 0));
        check_value("Master address", exp_maddr.pop_front(), m_araddr);
        check_value("Outstanding within depth", 32'd1,
                    32'(issued_cnt + 1 - popped_cnt <= DEPTH));
        ret_q.push_back(m_araddr);
        issued_cnt <= issued_cnt + 1;
      end
      m_arready <= take_bit();
      if (!m_rvalid || m_rready) begin
        if (ret_wait != 0) begin
          ret_wait <= ret_wait - 1;
          m_rvalid <= 1'b0;
        end else if (ret_q.size() != 0) begin
          ret_addr = ret_q.pop_front();
          m_rvalid <= 1'b1;
          m_rdata  <= ret_addr ^ 32'h5A5A0000;
          ret_wait <= int'(take_bits(2));  // 0 to 3 cycles
        end else begin
          m_rvalid <= 1'b0;
        end
      end
      if (stall_left != 0) begin
        stall_left <= stall_left - 1;
        s_rready   <= 1'b0;
      end else if (take_bits(3) == 4'd0) begin
        stall_left <= 16 + int'(take_bits(4));  // Long stall
        s_rready   <= 1'b0;
      end else begin
        s_rready <= take_bit();
      end
    end
  end

  // Slave R beats against the queued expectations
  always @(posedge clk) begin
    if (!reset && s_rvalid && s_rready) begin
      check_value("R beat expected", 32'd1, 32'(exp_rid.size() != 0));
      r_addr = exp_raddr.pop_front();
      check_value("RID", 32'(exp_rid.pop_front()), 32'(s_rid));
      check_value("RDATA", r_addr ^ 32'h5A5A0000, s_rdata);
      check_value("RLAST", 32'(exp_rlast.pop_front()), 32'(s_rlast));
      popped_cnt <= popped_cnt + 1;
    end
  end

  // One s_arready per command after its last master beat
  always @(posedge clk) begin
    if (!reset && s_arready) begin
      check_value("Command index", 32'd1, 32'(ar_cnt < NUM_CMDS));
      check_value("Beats issued at s_arready", cum_beats[ar_cnt], issued_cnt);
      ar_cnt <= ar_cnt + 1;
    end
  end

  initial begin
    build_expected();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    for (int c = 0; c < NUM_CMDS; c++) begin
      s_arid    <= tbl_id[c];
      s_araddr  <= tbl_addr[c];
      s_arlen   <= 8'(tbl_len[c]);
      s_arburst <= tbl_burst[c];
      s_arvalid <= 1'b1;
      do @(posedge clk); while (!s_arready);
    end
    s_arvalid <= 1'b0;
    wait (popped_cnt == total_beats);
    repeat (10) @(posedge clk);
    check_value("Extra R beat", 32'd0, 32'(s_rvalid));
    $display("STATUS: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    @(negedge reset);
    repeat (200 * total_beats) @(posedge clk);
    $display("Timeout: the read beats did not all return within %0d cycles",
             200 * total_beats);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== sources.f ====
+incdir+source
source/b2s_pkg.sv
source/b2s_rd_if.sv
source/b2s_rd_cmd_fsm.sv
source/b2s_cmd_translator.sv
source/b2s_r_channel.sv
source/b2s_rd_top.sv
verification/b2s_rd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module b2s_rd_tb \
  -Mdir obj_dir -o b2s_rd_sim

sim_out=$(./obj_dir/b2s_rd_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -qx "STATUS: PASS"; then
  exit 0
else
  exit 1
fi
